/* build.f */
verilog/synth_pkg.sv
verilog/midi_uart_rx.sv
verilog/midi_decoder.sv
verilog/note_div_table.sv
verilog/voice_bank.sv
verilog/voice_mixer.sv
verilog/poly_synth_top.sv
testbench/poly_synth_assert.sv
testbench/poly_synth_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the synthesizer testbench with Verilator, pass/fail taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module poly_synth_tb -f build.f -o poly_synth_sim || exit 1
./obj_dir/poly_synth_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* testbench/poly_synth_tb.sv */
/*
 * Testbench of the polyphonic synthesizer core
 * MIDI byte stimulus, level checks on the DAC word, timeout and result line
 */

module poly_synth_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BIT_CYCLES   = synth_pkg::BAUD_DIV;
	localparam int SMP          = synth_pkg::SAMPLE_DIV;
	localparam int MSG_BYTES    = 35;   // MIDI bytes sent over the whole run
	localparam int TEST_SAMPLES = 400;  // Sample periods spent waiting
	localparam int CYCLE_LIMIT  = MSG_BYTES * 10 * BIT_CYCLES + (TEST_SAMPLES + 40) * SMP;
	localparam int CHK_NONE     = 0;
	localparam int CHK_SAW      = 1;
	localparam int CHK_LEVEL    = 2;    // Multiples of the full square level

	logic        MHz10;
	logic        nrst;
	logic        en;
	logic [33:0] gpio_in;
	logic [33:0] gpio_out;
	logic [33:0] gpio_oeb;
	logic [11:0] dac;
	logic [11:0] last_dac = '0;
	logic [11:0] held;
	logic [6:0]  vel;
	bit [4095:0] seen = '0;
	int          seed = 43375;
	int          value_errs = 0;
	int          timing_errs = 0;
	int          cycles = 0;
	int          chk_mode = CHK_NONE;
	int          bound = 0;       // Largest allowed DAC word
	int          n_distinct = 0;

	assign dac = gpio_out[14:3];

	poly_synth_top i_dut (
		.MHz10    (MHz10),
		.nrst     (nrst),
		.en       (en),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oeb (gpio_oeb)
	);

	initial begin
		MHz10 = 1'b0;
		forever #4 MHz10 = ~MHz10;
	end

	always @(posedge MHz10) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Run stopped at cycle %0d before the tests were complete", cycles);
			$display("Errors: value %0d, timing %0d, assertion %0d",
				value_errs, timing_errs, i_dut.i_assert.fail_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// DAC word only moves at stores, so it is checked at each change
	always @(negedge MHz10) begin
		if (dac != last_dac) begin
			if (chk_mode == CHK_SAW) begin
				assert (dac <= bound) else begin
					value_errs++;
					$display("FAIL dac_out: got %h, limit %h", dac, bound);
				end
				if (!seen[dac]) begin
					seen[dac] = 1'b1;
					n_distinct++;
				end
			end else if (chk_mode == CHK_LEVEL) begin
				assert (dac % 253 == 0 && dac <= bound) else begin
					value_errs++;
					$display("FAIL dac_out: got %h, expected a multiple of fd up to %h",
						dac, bound);
				end
			end
		end
		last_dac = dac;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge MHz10);
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge MHz10);
			gpio_in[0] <= frame[i];
			wait_cycles(BIT_CYCLES - 1);
		end
	endtask

	task automatic send_note_msg(input logic [7:0] status, input logic [6:0] note,
		input logic [6:0] velocity);
		send_byte(status);
		send_byte({1'b0, note});
		send_byte({1'b0, velocity});
	endtask

	task automatic send_running(input logic [6:0] note, input logic [6:0] velocity);
		send_byte({1'b0, note});
		send_byte({1'b0, velocity});
	endtask

	// One press steps the wave mode once
	task automatic press_mode_button();
		@(posedge MHz10);
		gpio_in[2] <= 1'b1;
		wait_cycles(4);
		gpio_in[2] <= 1'b0;
		wait_cycles(4);
	endtask

	task automatic check_dac(input logic [11:0] expected);
		@(negedge MHz10);
		assert (dac == expected) else begin
			value_errs++;
			$display("FAIL dac_out: got %h, expected %h", dac, expected);
		end
	endtask

	// Polls for a zero or a nonzero DAC word
	task automatic await_dac(input bit want_zero, input int max_cycles, input string what);
		bit ok;
		ok = 1'b0;
		for (int i = 0; i < max_cycles && !ok; i++) begin
			@(negedge MHz10);
			ok = want_zero ? (dac == 12'd0) : (dac != 12'd0);
		end
		assert (ok) else begin
			timing_errs++;
			$display("dac_out did not %s within %0d cycles", what, max_cycles);
		end
	endtask

	initial begin
		nrst    = 1'b0;
		en      = 1'b0;
		gpio_in = 34'h1;  // Serial line idles high
		wait_cycles(8);
		nrst <= 1'b1;
		en   <= 1'b1;
		wait_cycles(4 * SMP);
		check_dac(12'd0);

		// Single saw voice
		vel = 7'($random(seed));
		if (vel < 7'd16)
			vel = vel + 7'd16;
		bound    = (int'(vel) * 255) >> 7;
		chk_mode = CHK_SAW;
		send_note_msg(8'h90, 7'd69, vel);
		wait_cycles(96 * SMP);  // Longer than one period of note 69
		assert (n_distinct >= 4) else begin
			value_errs++;
			$display("FAIL dac_out: %h distinct values, expected at least %h", n_distinct, 4);
		end
		send_note_msg(8'h80, 7'd69, 7'd64);
		await_dac(1'b1, 2 * SMP, "return to 0 after the saw note-off");
		chk_mode = CHK_NONE;

		// Button steps SAW to SQUARE
		press_mode_button();
		bound    = 253;
		chk_mode = CHK_LEVEL;
		send_note_msg(8'h90, 7'd69, 7'd127);
		wait_cycles(48 * SMP);

		bound = 4 * 253;
		send_note_msg(8'h90, 7'd60, 7'd127);
		send_running(7'd64, 7'd127);
		send_running(7'd67, 7'd127);
		send_running(7'd72, 7'd127);  // No free voice left
		wait_cycles(48 * SMP);

		send_note_msg(8'h80, 7'd60, 7'd64);
		bound = 3 * 253;
		wait_cycles(8 * SMP);
		send_note_msg(8'h90, 7'd64, 7'd0);  // Zero velocity releases
		bound = 2 * 253;
		wait_cycles(8 * SMP);
		send_note_msg(8'h80, 7'd67, 7'd0);
		send_running(7'd69, 7'd0);
		await_dac(1'b1, 2 * SMP, "return to 0 after all notes ended");
		bound = 0;              // Dropped note 72 must stay silent
		wait_cycles(80 * SMP);  // Longer than one period of note 72

		// Clear pin
		bound = 253;
		send_note_msg(8'h90, 7'd69, 7'd127);
		await_dac(1'b0, 48 * SMP, "rise above 0 after a note-on");
		@(posedge MHz10);
		gpio_in[1] <= 1'b1;
		@(posedge MHz10);
		gpio_in[1] <= 1'b0;
		wait_cycles(SMP + 10);
		check_dac(12'd0);
		chk_mode = CHK_NONE;

		// Freeze with en low, triangle rises at every store
		press_mode_button();
		send_note_msg(8'h90, 7'd69, 7'd127);
		await_dac(1'b0, 48 * SMP, "rise above 0 before the freeze");
		@(posedge MHz10);
		en <= 1'b0;
		@(negedge MHz10);
		held = dac;
		wait_cycles(3 * SMP);
		check_dac(held);
		@(posedge MHz10);
		en <= 1'b1;
		wait_cycles(4);

		$display("Errors: value %0d, timing %0d, assertion %0d",
			value_errs, timing_errs, i_dut.i_assert.fail_cnt);
		if (value_errs + timing_errs + i_dut.i_assert.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* testbench/poly_synth_assert.sv */
/*
 * Concurrent checks on the synthesizer top level ports
 * Fixed output enables, unused pins, DAC word after reset and while frozen
 */

module poly_synth_assert (
	input logic        MHz10,
	input logic        nrst,
	input logic        en,
	input logic [33:0] gpio_out,
	input logic [33:0] gpio_oeb
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_cnt = 0;  // Failed assertions so far
	logic [11:0] dac;

	assign dac = gpio_out[14:3];

	oeb_fixed: assert property (@(posedge MHz10) gpio_oeb == 34'h7)
	else begin
		fail_cnt++;
		$error("FAIL gpio_oeb: got %h, expected 7", gpio_oeb);
	end

	// Only pins 3 to 14 carry the sample
	unused_zero: assert property (@(posedge MHz10)
		gpio_out[33:15] == '0 && gpio_out[2:0] == '0)
	else begin
		fail_cnt++;
		$error("FAIL gpio_out: got %h, unused bits must be 0", gpio_out);
	end

	reset_zero: assert property (@(posedge MHz10) !nrst |=> dac == 12'd0)
	else begin
		fail_cnt++;
		$error("FAIL dac_out: got %h after reset, expected 0", dac);
	end

	en_hold: assert property (@(posedge MHz10) disable iff (!nrst) !en |=> $stable(dac))
	else begin
		fail_cnt++;
		$error("DAC word changed while en was low");
	end

endmodule

bind poly_synth_top poly_synth_assert i_assert (
	.MHz10    (MHz10),
	.nrst     (nrst),
	.en       (en),
	.gpio_out (gpio_out),
	.gpio_oeb (gpio_oeb)
);

/* verilog/poly_synth_top.sv */
/*
 * GPIO wrapper of the polyphonic synthesizer core
 * MIDI receiver, decoder, voice bank and mixer
 */

module poly_synth_top (
	input  logic        MHz10,
	input  logic        nrst,
	input  logic        en,
	input  logic [33:0] gpio_in,
	output logic [33:0] gpio_out,
	output logic [33:0] gpio_oeb
);

	logic [7:0]                                         rx_byte;
	logic                                               done;
	synth_pkg::midi_event_t                             midi_event;
	synth_pkg::voice_state_t [synth_pkg::NUM_VOICES-1:0] voices;
	logic [11:0]                                        dac_out;

	assign gpio_oeb = 34'h7;                         // Pins 0 to 2 are inputs
	assign gpio_out = {19'b0, dac_out, 3'b0};        // DAC word on pins 3 to 14

	midi_uart_rx i_uart (
		.MHz10   (MHz10),
		.nrst    (nrst),
		.en      (en),
		.ser_in  (gpio_in[0]),
		.rx_byte (rx_byte),
		.done    (done)
	);

	midi_decoder i_decoder (
		.MHz10      (MHz10),
		.nrst       (nrst),
		.en         (en),
		.rx_byte    (rx_byte),
		.done       (done),
		.midi_event (midi_event)
	);

	voice_bank i_voices (
		.MHz10      (MHz10),
		.nrst       (nrst),
		.en         (en),
		.clear      (gpio_in[1]),
		.midi_event (midi_event),
		.voices     (voices)
	);

	voice_mixer i_mixer (
		.MHz10        (MHz10),
		.nrst         (nrst),
		.en           (en),
		.wave_mode_pb (gpio_in[2]),
		.voices       (voices),
		.dac_out      (dac_out)
	);

endmodule

/* verilog/voice_mixer.sv */
/*
 * Voice mixer and DAC sample register
 * Sample divider, two cycle per voice sequencer, normalizer, wave shaper,
 * velocity scaling, accumulator and wave mode button
 */

module voice_mixer (
	input  logic                                                MHz10,
	input  logic                                                nrst,
	input  logic                                                en,
	input  logic                                                wave_mode_pb,
	input  synth_pkg::voice_state_t [synth_pkg::NUM_VOICES-1:0] voices,
	output logic [11:0]                                         dac_out
);

	logic [synth_pkg::SAMPLE_CNT_W-1:0] div_cnt;
	logic                               tick;
	logic                               busy;
	logic                               store_pend;
	logic [synth_pkg::VOICE_W:0]        step;  // Voice index above, phase bit 0
	synth_pkg::voice_state_t            cur;
	logic [7:0]                         n_q;
	logic [6:0]                         vel_q;
	logic                               act_q;
	logic [7:0]                         shaped;
	logic [14:0]                        product;
	logic [11:0]                        acc;
	logic                               pb_s1;
	logic                               pb_s2;
	logic                               pb_prev;
	synth_pkg::wave_mode_t              mode;

	// floor(count * 256 / period) by restoring division, count < period
	function automatic logic [7:0] normalize(
		input logic [synth_pkg::PHASE_W-1:0] count,
		input logic [synth_pkg::PHASE_W-1:0] period
	);
		logic [synth_pkg::PHASE_W:0] rem;
		logic [7:0]                  q;
		rem = {1'b0, count};
		for (int i = 7; i >= 0; i--) begin
			rem = rem << 1;
			q[i] = rem >= {1'b0, period};
			if (q[i])
				rem = rem - {1'b0, period};
		end
		return q;
	endfunction

	assign tick = en && (div_cnt == synth_pkg::SAMPLE_CNT_W'(synth_pkg::SAMPLE_DIV - 1));
	assign cur  = voices[step[synth_pkg::VOICE_W:1]];

	always_comb begin
		case (mode)
			synth_pkg::SQUARE:   shaped = n_q[7] ? 8'hFF : 8'h00;
			synth_pkg::TRIANGLE: shaped = n_q[7] ? {~n_q[6:0], 1'b0} : {n_q[6:0], 1'b0};
			default:             shaped = n_q;
		endcase
	end

	assign product = shaped * vel_q;

	// Voice k is sampled 2k+1 cycles after the tick, the sum lands 9 cycles after
	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			div_cnt    <= '0;
			busy       <= 1'b0;
			store_pend <= 1'b0;
			step       <= '0;
			act_q      <= 1'b0;
			acc        <= '0;
			dac_out    <= '0;
		end else if (en) begin
			div_cnt    <= div_cnt + 1'b1;
			store_pend <= 1'b0;
			if (tick) begin
				busy <= 1'b1;
				step <= '0;
				acc  <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (!step[0])
					act_q <= cur.active;  // Fetch cycle
				else if (act_q)
					acc <= acc + {4'b0, product[14:7]};  // Add cycle
				if (step == '1) begin
					busy       <= 1'b0;
					store_pend <= 1'b1;
				end
			end
			if (store_pend)
				dac_out <= acc;
		end
	end

	always_ff @(posedge MHz10) begin
		if (en && busy && !step[0]) begin
			n_q   <= normalize(cur.count, cur.period);
			vel_q <= cur.velocity;
		end
	end

	// Button edge steps SAW, SQUARE, TRIANGLE
	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			pb_s1   <= 1'b0;
			pb_s2   <= 1'b0;
			pb_prev <= 1'b0;
			mode    <= synth_pkg::SAW;
		end else if (en) begin
			pb_s1   <= wave_mode_pb;
			pb_s2   <= pb_s1;
			pb_prev <= pb_s2;
			if (pb_s2 && !pb_prev) begin
				case (mode)
					synth_pkg::SAW:    mode <= synth_pkg::SQUARE;
					synth_pkg::SQUARE: mode <= synth_pkg::TRIANGLE;
					default:           mode <= synth_pkg::SAW;
				endcase
			end
		end
	end

endmodule

/* verilog/voice_bank.sv */
/*
 * Four voice bank with allocation and sawtooth phase counters
 * Lowest free voice takes a note-on, note-off releases by note match
 */

module voice_bank (
	input  logic                                                MHz10,
	input  logic                                                nrst,
	input  logic                                                en,
	input  logic                                                clear,
	input  synth_pkg::midi_event_t                              midi_event,
	output synth_pkg::voice_state_t [synth_pkg::NUM_VOICES-1:0] voices
);

	logic [synth_pkg::PHASE_W-1:0] new_period;
	logic [synth_pkg::VOICE_W-1:0] free_idx;
	logic                          free_found;

	note_div_table i_note_div (
		.note   (midi_event.note),
		.period (new_period)
	);

	// Priority search, scanning down so the lowest index wins
	always_comb begin
		free_idx   = '0;
		free_found = 1'b0;
		for (int i = synth_pkg::NUM_VOICES - 1; i >= 0; i--) begin
			if (!voices[i].active) begin
				free_idx   = synth_pkg::VOICE_W'(i);
				free_found = 1'b1;
			end
		end
	end

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			voices <= '0;
		end else if (en) begin
			for (int i = 0; i < synth_pkg::NUM_VOICES; i++) begin
				if (voices[i].active) begin
					if (voices[i].count == voices[i].period - 1'b1)
						voices[i].count <= '0;
					else
						voices[i].count <= voices[i].count + 1'b1;
				end
				if (clear)
					voices[i].active <= 1'b0;
				else if (midi_event.note_off && voices[i].note == midi_event.note)
					voices[i].active <= 1'b0;  // All voices on this note
			end
			// A note-on with every voice busy is dropped
			if (!clear && midi_event.note_on && free_found) begin
				voices[free_idx] <= '{
					active:   1'b1,
					note:     midi_event.note,
					velocity: midi_event.velocity,
					count:    '0,
					period:   new_period
				};
			end
		end
	end

endmodule

/* verilog/note_div_table.sv */
/*
 * Note number to phase counter period at 10 MHz
 * Lowest octave table, shifted right once per octave
 */

module note_div_table (
	input  logic [6:0]                    note,
	output logic [synth_pkg::PHASE_W-1:0] period
);

	logic [3:0]                    octave;
	logic [3:0]                    semi;
	logic [synth_pkg::PHASE_W-1:0] base;

	always_comb begin
		octave = 4'(note / 7'd12);
		semi   = 4'(note % 7'd12);
		if (octave == 4'd0)
			octave = 4'd1;  // Clamp notes 0 to 11 onto C0 to B0
	end

	always_comb begin
		case (semi)
			4'd0:    base = 20'd611561;  // C0
			4'd1:    base = 20'd577237;
			4'd2:    base = 20'd544840;
			4'd3:    base = 20'd514260;
			4'd4:    base = 20'd485396;
			4'd5:    base = 20'd458152;
			4'd6:    base = 20'd432438;
			4'd7:    base = 20'd408168;
			4'd8:    base = 20'd385260;
			4'd9:    base = 20'd363636;  // A0, 27.5 Hz
			4'd10:   base = 20'd343227;
			default: base = 20'd323962;  // B0
		endcase
	end

	assign period = base >> (octave - 4'd1);

endmodule

/* verilog/midi_decoder.sv */
/*
 * MIDI message parser with running status
 * Emits note-on and note-off events, other messages are ignored
 */

module midi_decoder (
	input  logic                   MHz10,
	input  logic                   nrst,
	input  logic                   en,
	input  logic [7:0]             rx_byte,
	input  logic                   done,
	output synth_pkg::midi_event_t midi_event
);

	logic       run_valid;  // Running status is a note message
	logic       run_on;     // Running status is note-on
	logic       data_idx;   // Next data byte is velocity
	logic [6:0] note_q;
	logic       is_data;

	assign is_data = done && !rx_byte[7];

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			run_valid  <= 1'b0;
			run_on     <= 1'b0;
			data_idx   <= 1'b0;
			midi_event <= '0;
		end else if (en) begin
			midi_event.note_on  <= 1'b0;
			midi_event.note_off <= 1'b0;
			if (done && rx_byte[7]) begin
				// Real-time bytes F8 to FF may interleave and keep the status
				if (rx_byte[7:3] != 5'b11111) begin
					run_valid <= (rx_byte[7:4] == 4'h8) || (rx_byte[7:4] == 4'h9);
					run_on    <= rx_byte[7:4] == 4'h9;
					data_idx  <= 1'b0;
				end
			end else if (is_data && run_valid) begin
				data_idx <= !data_idx;
				if (data_idx) begin
					midi_event.note     <= note_q;
					midi_event.velocity <= rx_byte[6:0];
					// Velocity 0 on a note-on means release
					midi_event.note_on  <= run_on && (rx_byte[6:0] != 7'd0);
					midi_event.note_off <= !run_on || (rx_byte[6:0] == 7'd0);
				end
			end
		end
	end

	always_ff @(posedge MHz10) begin
		if (en && is_data && run_valid && !data_idx)
			note_q <= rx_byte[6:0];
	end

endmodule

/* verilog/midi_uart_rx.sv */
/*
 * MIDI serial receiver, 8N1 at 31250 baud
 * Two flop input synchronizer, start edge detect, mid-bit sampling
 */

module midi_uart_rx (
	input  logic       MHz10,
	input  logic       nrst,
	input  logic       en,
	input  logic       ser_in,
	output logic [7:0] rx_byte,
	output logic       done
);

	logic                             sync1;
	logic                             sync2;
	logic                             prev;
	logic                             busy;
	logic [3:0]                       bit_idx;   // 0 start, 1 to 8 data, 9 stop
	logic [synth_pkg::BAUD_CNT_W-1:0] baud_cnt;
	logic                             sample;

	assign sample = busy && (baud_cnt == '0);

	always_ff @(posedge MHz10 or negedge nrst) begin
		if (!nrst) begin
			sync1    <= 1'b1;  // Line idles high
			sync2    <= 1'b1;
			prev     <= 1'b1;
			busy     <= 1'b0;
			bit_idx  <= '0;
			baud_cnt <= '0;
			done     <= 1'b0;
		end else if (en) begin
			sync1 <= ser_in;
			sync2 <= sync1;
			prev  <= sync2;
			done  <= 1'b0;
			if (!busy) begin
				if (prev && !sync2) begin  // Falling edge of start bit
					busy     <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= synth_pkg::BAUD_CNT_W'(synth_pkg::BAUD_DIV / 2 - 1);
				end
			end else if (!sample) begin
				baud_cnt <= baud_cnt - 1'b1;
			end else begin
				baud_cnt <= synth_pkg::BAUD_CNT_W'(synth_pkg::BAUD_DIV - 1);
				bit_idx  <= bit_idx + 1'b1;
				if (bit_idx == 4'd0 && sync2)
					busy <= 1'b0;  // Glitch, not a real start bit
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					done <= sync2;  // Framing error drops the byte
				end
			end
		end
	end

	// Data arrives LSB first
	always_ff @(posedge MHz10) begin
		if (en && sample && bit_idx >= 4'd1 && bit_idx <= 4'd8)
			rx_byte <= {sync2, rx_byte[7:1]};
	end

endmodule

/* verilog/synth_pkg.sv */
/*
 * Shared constants and types of the polyphonic synthesizer core
 * Timing divisors for the 10 MHz clock, voice and phase sizes
 * MIDI event, voice state and wave mode types
 */

package synth_pkg;

	localparam int NUM_VOICES = 4;
	localparam int VOICE_W = 2;              // Voice index width

	localparam int BAUD_DIV = 320;           // 10 MHz / 31250 baud
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

	localparam int SAMPLE_DIV = 256;         // About 39 kHz sample rate
	localparam int SAMPLE_CNT_W = $clog2(SAMPLE_DIV);

	localparam int PHASE_W = 20;             // Lowest note period needs 20 bits

	// One decoded note message, pulses last a single cycle
	typedef struct packed {
		logic       note_on;
		logic       note_off;
		logic [6:0] note;
		logic [6:0] velocity;
	} midi_event_t;

	// State of one oscillator voice
	typedef struct packed {
		logic               active;
		logic [6:0]         note;
		logic [6:0]         velocity;
		logic [PHASE_W-1:0] count;   // Sawtooth phase, 0 to period-1
		logic [PHASE_W-1:0] period;  // Clocks per waveform cycle
	} voice_state_t;

	typedef enum logic [1:0] {
		SAW      = 2'd0,
		SQUARE   = 2'd1,
		TRIANGLE = 2'd2
	} wave_mode_t;

endpackage
